//--- aluLane.sv
`timescale 1ns/1ps

module aluLane import isaPkg::*, execPkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        laneValid,
  input  laneOp_t     laneOp,
  output logic        doneValid,
  output laneResult_t done
);

  logic isMul;
  logic zeroFlag;
  logic [31:0] aluValue;
  logic [31:0] aluExc;

  // multiply pipeline, two inner stages plus the shared output register
  logic mulValid1;
  logic mulValid2;
  laneOp_t mulOp1;
  logic mulZero1;
  laneResult_t mulRes2;

  assign isMul    = (laneOp.op == OP_MUL);
  assign zeroFlag = (laneOp.operandA == laneOp.operandB);

  always_comb begin
    case (laneOp.op)
      OP_ADD:  aluValue = laneOp.operandA + laneOp.operandB;
      OP_SUB:  aluValue = laneOp.operandA - laneOp.operandB;
      OP_OR:   aluValue = laneOp.operandA | laneOp.operandB;
      OP_AND:  aluValue = laneOp.operandA & laneOp.operandB;
      OP_PASS: aluValue = laneOp.operandA;
      default: aluValue = '0; // illegal, mul goes the long way
    endcase
  end

  assign aluExc = (laneOp.op == OP_ILLEGAL) ? EXC_ILLEGAL : EXC_NONE;

  always_ff @(posedge clk) begin
    if (rst) begin
      mulValid1 <= 1'b0;
      mulValid2 <= 1'b0;
      doneValid <= 1'b0;
    end else begin
      mulValid1 <= laneValid && isMul;
      mulValid2 <= mulValid1;
      doneValid <= mulValid2 || (laneValid && !isMul);
    end
  end

  always_ff @(posedge clk) begin
    if (laneValid && isMul) begin
      mulOp1   <= laneOp;
      mulZero1 <= zeroFlag; // flag travels with the product
    end
    if (mulValid1) begin
      mulRes2 <= '{value:         mulOp1.operandA * mulOp1.operandB,
                   zero:          mulZero1,
                   exceptionCode: EXC_NONE,
                   tag:           mulOp1.tag,
                   seq:           mulOp1.seq};
    end
  end

  // merge point, a lane never has both paths finishing together
  always_ff @(posedge clk) begin
    if (mulValid2) begin
      done <= mulRes2;
    end else if (laneValid) begin
      done <= '{value:         aluValue,
                zero:          zeroFlag,
                exceptionCode: aluExc,
                tag:           laneOp.tag,
                seq:           laneOp.seq};
    end
  end

endmodule

//--- execCluster.f
isaPkg.sv
execPkg.sv
issueDecoder.sv
aluLane.sv
resultReorder.sv
execCluster.sv
execClusterMonitor.sv
execCluster_chk.sv
execCluster_tb.sv

//--- execCluster.sv
`timescale 1ns/1ps

module execCluster import execPkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        issueValid,
  input  issueReq_t   issueReq,
  output logic        resultValid,
  output execResult_t result
);

  logic [NUM_LANES-1:0] laneValid;
  laneOp_t laneOp [NUM_LANES];
  logic [NUM_LANES-1:0] doneValid;
  laneResult_t done [NUM_LANES];

  issueDecoder decoder (
    .clk        (clk),
    .rst        (rst),
    .issueValid (issueValid),
    .issueReq   (issueReq),
    .laneValid  (laneValid),
    .laneOp     (laneOp)
  );

  // identical lanes, fed round-robin
  genvar lane;
  generate
    for (lane = 0; lane < NUM_LANES; lane++) begin : genLane
      aluLane alu (
        .clk       (clk),
        .rst       (rst),
        .laneValid (laneValid[lane]),
        .laneOp    (laneOp[lane]),
        .doneValid (doneValid[lane]),
        .done      (done[lane])
      );
    end
  endgenerate

  resultReorder reorder (
    .clk         (clk),
    .rst         (rst),
    .doneValid   (doneValid),
    .done        (done),
    .resultValid (resultValid),
    .result      (result)
  );

endmodule

//--- execClusterMonitor.sv
`timescale 1ns/1ps

module execClusterMonitor import isaPkg::*, execPkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        expValid,
  input  execResult_t expResult,
  input  logic        resultValid,
  input  execResult_t result,
  output int          mismatchCount,
  output int          unexpectedCount,
  output int          pendingCount
);

  execResult_t expQueue [$]; // expected results in issue order
  execResult_t expHead;

  always @(posedge clk) begin
    if (rst) begin
      expQueue.delete();
      mismatchCount   = 0;
      unexpectedCount = 0;
    end else begin
      if (expValid) begin
        expQueue.push_back(expResult);
      end
      if (resultValid) begin
        if (expQueue.size() == 0) begin
          unexpectedCount++;
          $display("At %0t a result with tag %0d came out while no result was expected",
                   $time, result.tag);
        end else begin
          expHead = expQueue.pop_front();
          if (result !== expHead) begin
            mismatchCount++;
            $display("Error at %0t: tag/value/zero/exc %0d/%h/%b/%0d, expected %0d/%h/%b/%0d",
                     $time, result.tag, result.value, result.zero, result.exceptionCode,
                     expHead.tag, expHead.value, expHead.zero, expHead.exceptionCode);
          end
        end
      end
    end
    pendingCount = expQueue.size(); // still waiting for these
  end

endmodule

//--- execCluster_chk.sv
`timescale 1ns/1ps

module execCluster_chk import execPkg::*; (
  input logic                 clk,
  input logic                 rst,
  input logic                 issueValid,
  input logic [NUM_LANES-1:0] laneValid,
  input logic                 resultValid
);

  logic seenIssue;
  int assertFailCount = 0;

  always_ff @(posedge clk) begin
    if (rst) begin
      seenIssue <= 1'b0;
    end else if (issueValid) begin
      seenIssue <= 1'b1;
    end
  end

  laneOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(laneValid))
    else begin
      assertFailCount++;
      $error("more than one lane strobed in one cycle");
    end

  // first reset edge skipped, the output register is still settling
  quietInReset: assert property (@(posedge clk) (rst && $past(rst)) |-> !resultValid)
    else begin
      assertFailCount++;
      $error("resultValid high during reset");
    end

  noEarlyResult: assert property (@(posedge clk) disable iff (rst) resultValid |-> seenIssue)
    else begin
      assertFailCount++;
      $error("result retired before any issue");
    end

endmodule

bind execCluster execCluster_chk chk (
  .clk         (clk),
  .rst         (rst),
  .issueValid  (issueValid),
  .laneValid   (laneValid),
  .resultValid (resultValid)
);

//--- execCluster_tb.sv
`timescale 1ns/1ps

module execCluster_tb import isaPkg::*, execPkg::*; ();

  localparam int TABLE_LEN      = 20;
  localparam int RANDOM_COUNT   = 64; // longer than NUM_LANES * ROB_DEPTH cycles
  localparam int TIMEOUT_CYCLES = (TABLE_LEN + RANDOM_COUNT) * 10 + 200;
  localparam int RAND_SEED      = 50354;

  typedef struct packed {
    instrWord_t  instr;
    logic [31:0] rs1Val;
    logic [31:0] rs2Val;
    logic [31:0] value;
    logic        zero;
    logic [31:0] exc;
  } tableEntry_t;

  logic clk = 1'b0;
  logic rst = 1'b1;
  logic issueValid;
  issueReq_t issueReq;
  logic resultValid;
  execResult_t result;
  logic expValid;
  execResult_t expResult;
  int mismatchCount;
  int unexpectedCount;
  int pendingCount;

  tableEntry_t testTable [TABLE_LEN];
  instrWord_t addI, subI, mulI, orI, andI;
  instrWord_t instrBySel [5];
  logic [TAG_WIDTH-1:0] tagCount = '0;
  int opSel;
  int waitCycles;
  logic [31:0] a, b, value;

  always #2 clk = ~clk;

  execCluster uut (
    .clk         (clk),
    .rst         (rst),
    .issueValid  (issueValid),
    .issueReq    (issueReq),
    .resultValid (resultValid),
    .result      (result)
  );

  execClusterMonitor monitor (
    .clk             (clk),
    .rst             (rst),
    .expValid        (expValid),
    .expResult       (expResult),
    .resultValid     (resultValid),
    .result          (result),
    .mismatchCount   (mismatchCount),
    .unexpectedCount (unexpectedCount),
    .pendingCount    (pendingCount)
  );

  function automatic instrWord_t rInstr(logic [6:0] f7, logic [2:0] f3, logic [6:0] opc);
    instrWord_t w;
    w.rView = '{funct7: f7, rs2: 5'd2, rs1: 5'd1, funct3: f3, rd: 5'd3, opcode: opc};
    return w;
  endfunction

  function automatic instrWord_t iInstr(logic [11:0] imm, logic [2:0] f3, logic [6:0] opc);
    instrWord_t w;
    w.iView = '{imm12: imm, rs1: 5'd1, funct3: f3, rd: 5'd3, opcode: opc};
    return w;
  endfunction

  // store immediate is split around rs2/rs1
  function automatic instrWord_t sInstr(logic [11:0] imm);
    instrWord_t w;
    w.sView = '{immHi: imm[11:5], rs2: 5'd2, rs1: 5'd1, funct3: 3'b010,
                immLo: imm[4:0], opcode: OPCODE_STORE};
    return w;
  endfunction

  task automatic fillTable();
    addI = rInstr(FUNCT7_BASE, FUNCT3_ADD, OPCODE_ALU);
    subI = rInstr(FUNCT7_SUB, FUNCT3_ADD, OPCODE_ALU);
    mulI = rInstr(FUNCT7_MUL, FUNCT3_ADD, OPCODE_ALU);
    orI  = rInstr(FUNCT7_BASE, FUNCT3_OR, OPCODE_ALU);
    andI = rInstr(FUNCT7_BASE, FUNCT3_AND, OPCODE_ALU);
    instrBySel = '{addI, subI, mulI, orI, andI};
    testTable[0]  = '{mulI, 32'd6, 32'd7, 32'd42, 1'b0, EXC_NONE};
    testTable[1]  = '{addI, 32'd5, 32'd7, 32'd12, 1'b0, EXC_NONE};
    testTable[2]  = '{subI, 32'd10, 32'd3, 32'd7, 1'b0, EXC_NONE};
    testTable[3]  = '{mulI, 32'h0001_0000, 32'h0001_0001, 32'h0001_0000, 1'b0, EXC_NONE};
    testTable[4]  = '{orI, 32'hF0F0_0000, 32'h0000_0F0F, 32'hF0F0_0F0F, 1'b0, EXC_NONE};
    testTable[5]  = '{andI, 32'hFF00_FF00, 32'h0FF0_0FF0, 32'h0F00_0F00, 1'b0, EXC_NONE};
    testTable[6]  = '{subI, 32'd9, 32'd9, 32'd0, 1'b1, EXC_NONE};
    testTable[7]  = '{mulI, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'd1, 1'b1, EXC_NONE};
    testTable[8]  = '{addI, 32'hFFFF_FFFF, 32'd1, 32'd0, 1'b0, EXC_NONE}; // wraps
    testTable[9]  = '{iInstr(12'hFFC, FUNCT3_ADD, OPCODE_ALU_IMM),
                      32'd100, 32'd0, 32'd96, 1'b0, EXC_NONE};
    testTable[10] = '{iInstr(12'hFFC, FUNCT3_ADD, OPCODE_ALU_IMM),
                      32'hFFFF_FFFC, 32'd0, 32'hFFFF_FFF8, 1'b1, EXC_NONE};
    testTable[11] = '{iInstr(12'h7FF, 3'b010, OPCODE_LOAD),
                      32'h0000_1000, 32'd0, 32'h0000_17FF, 1'b0, EXC_NONE};
    testTable[12] = '{sInstr(12'hFF8), 32'h0000_2000, 32'h55, 32'h0000_1FF8, 1'b0, EXC_NONE};
    testTable[13] = '{rInstr(FUNCT7_BASE, 3'b000, OPCODE_BRANCH),
                      32'h40, 32'h40, 32'h80, 1'b1, EXC_NONE};
    testTable[14] = '{rInstr(FUNCT7_BASE, 3'b000, OPCODE_BRANCH),
                      32'd1, 32'd2, 32'd3, 1'b0, EXC_NONE};
    testTable[15] = '{rInstr(FUNCT7_BASE, 3'b000, OPCODE_JUMP),
                      32'h1234, 32'd0, 32'h1234, 1'b0, EXC_NONE};
    // undecoded encodings
    testTable[16] = '{rInstr(FUNCT7_BASE, 3'b000, 7'h7F), 32'd3, 32'd3, 32'd0, 1'b1, EXC_ILLEGAL};
    testTable[17] = '{rInstr(FUNCT7_BASE, 3'b001, OPCODE_ALU), 32'd1, 32'd2, 32'd0, 1'b0,
                      EXC_ILLEGAL};
    testTable[18] = '{rInstr(FUNCT7_SUB, FUNCT3_OR, OPCODE_ALU), 32'd5, 32'd6, 32'd0, 1'b0,
                      EXC_ILLEGAL};
    testTable[19] = '{iInstr(12'd7, FUNCT3_OR, OPCODE_ALU_IMM), 32'd7, 32'd0, 32'd0, 1'b1,
                      EXC_ILLEGAL};
  endtask

  // one issue plus its expectation, 1 ns after the edge
  task automatic sendIssue(instrWord_t instr, logic [31:0] rs1, logic [31:0] rs2,
                           logic [31:0] expVal, logic expZero, logic [31:0] expExc);
    @(posedge clk);
    #1;
    issueValid = 1'b1;
    issueReq   = '{instr, rs1, rs2, tagCount};
    expValid   = 1'b1;
    expResult  = '{expVal, expZero, expExc, tagCount};
    tagCount   = tagCount + TAG_WIDTH'(1);
  endtask

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("TB FAILED");
    $finish;
  end

  initial begin
    void'($urandom(RAND_SEED));
    issueValid = 1'b0;
    issueReq   = '0;
    expValid   = 1'b0;
    expResult  = '0;
    rst        = 1'b1;
    fillTable();
    repeat (10) @(posedge clk);
    #1 rst = 1'b0;

    for (int i = 0; i < TABLE_LEN; i++) begin
      sendIssue(testTable[i].instr, testTable[i].rs1Val, testTable[i].rs2Val,
                testTable[i].value, testTable[i].zero, testTable[i].exc);
    end

    for (int i = 0; i < RANDOM_COUNT; i++) begin
      opSel = (i % 16 < 4) ? 2 : int'($urandom % 5); // runs of mul
      a = $urandom;
      b = ($urandom % 4 == 0) ? a : $urandom; // equal operands now and then
      case (opSel)
        0: value = a + b;
        1: value = a - b;
        2: value = a * b;
        3: value = a | b;
        default: value = a & b;
      endcase
      sendIssue(instrBySel[opSel], a, b, value, a == b, EXC_NONE);
    end

    @(posedge clk);
    #1;
    issueValid = 1'b0;
    expValid   = 1'b0;

    waitCycles = 0;
    while (pendingCount != 0 && waitCycles < 100) begin
      @(posedge clk);
      #1;
      waitCycles++;
    end
    repeat (10) @(posedge clk); // catch stray results
    #1;
    if (pendingCount != 0) begin
      $display("%0d expected results never came out of the DUT", pendingCount);
    end
    $display("Errors: %0d mismatched, %0d unexpected, %0d missing, %0d assertion",
             mismatchCount, unexpectedCount, pendingCount, uut.chk.assertFailCount);
    if (mismatchCount == 0 && unexpectedCount == 0 && pendingCount == 0 &&
        uut.chk.assertFailCount == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- execPkg.sv
package execPkg;
  import isaPkg::*;

  localparam int NUM_LANES  = 4;
  localparam int ROB_DEPTH  = 8; // power of two, >= NUM_LANES + 4
  localparam int TAG_WIDTH  = 8;
  localparam int SEQ_WIDTH  = $clog2(ROB_DEPTH);
  localparam int LANE_WIDTH = $clog2(NUM_LANES);

  // 104 bits
  typedef struct packed {
    instrWord_t           instr;
    logic [31:0]          rs1Val;
    logic [31:0]          rs2Val;
    logic [TAG_WIDTH-1:0] tag;
  } issueReq_t;

  typedef struct packed {
    aluOp_t               op;
    logic [31:0]          operandA;
    logic [31:0]          operandB;
    logic [TAG_WIDTH-1:0] tag;
    logic [SEQ_WIDTH-1:0] seq; // reorder slot index
  } laneOp_t;

  typedef struct packed {
    logic [31:0]          value;
    logic                 zero;
    logic [31:0]          exceptionCode;
    logic [TAG_WIDTH-1:0] tag;
    logic [SEQ_WIDTH-1:0] seq;
  } laneResult_t;

  typedef struct packed {
    logic [31:0]          value;
    logic                 zero;
    logic [31:0]          exceptionCode;
    logic [TAG_WIDTH-1:0] tag;
  } execResult_t;

endpackage

//--- isaPkg.sv
package isaPkg;

  // major opcodes, RV32 encoding
  localparam logic [6:0] OPCODE_ALU     = 7'b0110011;
  localparam logic [6:0] OPCODE_ALU_IMM = 7'b0010011;
  localparam logic [6:0] OPCODE_BRANCH  = 7'b1100011;
  localparam logic [6:0] OPCODE_JUMP    = 7'b1101111;
  localparam logic [6:0] OPCODE_LOAD    = 7'b0000011;
  localparam logic [6:0] OPCODE_STORE   = 7'b0100011;

  localparam logic [6:0] FUNCT7_BASE = 7'b0000000; // add, or, and
  localparam logic [6:0] FUNCT7_SUB  = 7'b0100000;
  localparam logic [6:0] FUNCT7_MUL  = 7'b0000001; // M extension, low word only

  localparam logic [2:0] FUNCT3_ADD = 3'b000; // also addi, sub and mul
  localparam logic [2:0] FUNCT3_OR  = 3'b110;
  localparam logic [2:0] FUNCT3_AND = 3'b111;

  localparam logic [31:0] EXC_NONE    = 32'd0;
  localparam logic [31:0] EXC_ILLEGAL = 32'd1;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rType_t;

  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } iType_t;

  // store splits its immediate around rs2/rs1
  typedef struct packed {
    logic [6:0] immHi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] immLo;
    logic [6:0] opcode;
  } sType_t;

  // opcode sits in the same bits in every view
  typedef union packed {
    rType_t rView;
    iType_t iView;
    sType_t sView;
  } instrWord_t;

  typedef enum logic [2:0] {
    OP_ADD     = 3'd0,
    OP_SUB     = 3'd1,
    OP_MUL     = 3'd2,
    OP_OR      = 3'd3,
    OP_AND     = 3'd4,
    OP_PASS    = 3'd5, // jump, operand A straight through
    OP_ILLEGAL = 3'd6
  } aluOp_t;

endpackage

//--- issueDecoder.sv
`timescale 1ns/1ps

module issueDecoder import isaPkg::*, execPkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 issueValid,
  input  issueReq_t            issueReq,
  output logic [NUM_LANES-1:0] laneValid,
  output laneOp_t              laneOp [NUM_LANES]
);

  instrWord_t instr;
  aluOp_t decOp;
  logic [31:0] decB;
  logic [31:0] immI;
  logic [31:0] immS;
  logic [LANE_WIDTH-1:0] lanePtr;
  logic [SEQ_WIDTH-1:0] seqCnt;

  assign instr = issueReq.instr;

  // sign-extended immediates from the two views
  assign immI = {{20{instr.iView.imm12[11]}}, instr.iView.imm12};
  assign immS = {{20{instr.sView.immHi[6]}}, instr.sView.immHi, instr.sView.immLo};

  always_comb begin
    decOp = OP_ILLEGAL;
    decB  = issueReq.rs2Val;
    case (instr.rView.opcode)
      OPCODE_ALU: begin
        case (instr.rView.funct7)
          FUNCT7_BASE: begin
            case (instr.rView.funct3)
              FUNCT3_ADD: decOp = OP_ADD;
              FUNCT3_OR:  decOp = OP_OR;
              FUNCT3_AND: decOp = OP_AND;
              default:    decOp = OP_ILLEGAL;
            endcase
          end
          FUNCT7_SUB: begin
            if (instr.rView.funct3 == FUNCT3_ADD) decOp = OP_SUB;
          end
          FUNCT7_MUL: begin
            if (instr.rView.funct3 == FUNCT3_ADD) decOp = OP_MUL;
          end
          default: decOp = OP_ILLEGAL;
        endcase
      end
      OPCODE_ALU_IMM: begin
        if (instr.iView.funct3 == FUNCT3_ADD) decOp = OP_ADD; // addi only
        decB = immI;
      end
      OPCODE_BRANCH: decOp = OP_ADD; // target sum, zero flag does the compare
      OPCODE_LOAD: begin
        decOp = OP_ADD;
        decB  = immI;
      end
      OPCODE_STORE: begin
        decOp = OP_ADD;
        decB  = immS;
      end
      OPCODE_JUMP: decOp = OP_PASS;
      default: decOp = OP_ILLEGAL;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      laneValid <= '0;
      lanePtr   <= '0;
      seqCnt    <= '0;
    end else begin
      laneValid <= '0;
      if (issueValid) begin
        laneValid[lanePtr] <= 1'b1;
        lanePtr <= (lanePtr == LANE_WIDTH'(NUM_LANES - 1)) ? '0 : lanePtr + 1'b1;
        seqCnt  <= seqCnt + 1'b1; // wraps at ROB_DEPTH
      end
    end
  end

  // only the strobed lane's slot changes
  always_ff @(posedge clk) begin
    if (issueValid) begin
      laneOp[lanePtr] <= '{op:       decOp,
                           operandA: issueReq.rs1Val,
                           operandB: decB,
                           tag:      issueReq.tag,
                           seq:      seqCnt};
    end
  end

endmodule

//--- resultReorder.sv
`timescale 1ns/1ps

module resultReorder import execPkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [NUM_LANES-1:0] doneValid,
  input  laneResult_t          done [NUM_LANES],
  output logic                 resultValid,
  output execResult_t          result
);

  logic [ROB_DEPTH-1:0] slotFilled;
  execResult_t slotData [ROB_DEPTH];
  logic [SEQ_WIDTH-1:0] headPtr; // next seq to retire
  logic headReady;

  assign headReady = slotFilled[headPtr];

  // filled bits and head pointer
  always_ff @(posedge clk) begin
    if (rst) begin
      slotFilled  <= '0;
      headPtr     <= '0;
      resultValid <= 1'b0;
    end else begin
      resultValid <= headReady;
      if (headReady) begin
        slotFilled[headPtr] <= 1'b0;
        headPtr <= headPtr + 1'b1; // power-of-two depth wraps on its own
      end
      // writes after the clear, so a refill of the head slot is kept
      for (int k = 0; k < NUM_LANES; k++) begin
        if (doneValid[k]) begin
          slotFilled[done[k].seq] <= 1'b1;
        end
      end
    end
  end

  // slot storage, any number of lanes may write in one cycle
  always_ff @(posedge clk) begin
    for (int k = 0; k < NUM_LANES; k++) begin
      if (doneValid[k]) begin
        slotData[done[k].seq] <= '{value:         done[k].value,
                                   zero:          done[k].zero,
                                   exceptionCode: done[k].exceptionCode,
                                   tag:           done[k].tag};
      end
    end
  end

  always_ff @(posedge clk) begin
    if (headReady) begin
      result <= slotData[headPtr];
    end
  end

endmodule

//--- runSim.sh
#!/bin/sh
# build and run the execCluster testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module execCluster_tb -f execCluster.f -o simExec
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/simExec > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TB FAILED" "$LOG"; then
  exit 1
fi
exit 0
